//--- array/mac_pe.sv
`timescale 1ns/100ps

module mac_pe (
    input  logic                  clk,
    input  logic                  rst,
    input  systolic_pkg::a_lane_t a_in,
    input  systolic_pkg::b_lane_t b_in,
    output systolic_pkg::a_lane_t a_out,
    output systolic_pkg::b_lane_t b_out,
    output systolic_pkg::acc_t    sum,
    output logic                  done
);
    import systolic_pkg::*;

    logic signed [2*data_w-1:0] product;
    acc_t                       product_ext;

    // operand registers, also the hand-off to the right and lower cells.
    always_ff @(posedge clk) begin
        if (rst) begin
            a_out <= '0;
        end else begin
            a_out <= a_in;
        end
    end

    always_ff @(posedge clk) begin
        b_out <= b_in;
    end

    assign product     = a_out.data * b_out.data;
    assign product_ext = product;

    // first overwrites, so stale sums from an old job never leak.
    always_ff @(posedge clk) begin
        if (a_out.valid) begin
            if (a_out.first) begin
                sum <= product_ext;
            end else begin
                sum <= sum + product_ext;
            end
        end
    end

    // one-cycle pulse once the closing beat is folded in.
    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= a_out.valid & a_out.last;
        end
    end

endmodule

//--- array/pe_grid.sv
`timescale 1ns/100ps

module pe_grid (
    input  logic                     clk,
    input  logic                     rst,
    input  systolic_pkg::a_vec_t     a_skewed,
    input  systolic_pkg::b_vec_t     b_skewed,
    output systolic_pkg::done_grid_t done,
    output systolic_pkg::sum_grid_t  sums
);
    import systolic_pkg::*;

    // registered operands leaving each cell, indexed [row][col].
    a_lane_t a_fwd [array_dim][array_dim];
    b_lane_t b_fwd [array_dim][array_dim];

    for (genvar i = 0; i < array_dim; i++) begin : g_row
        for (genvar j = 0; j < array_dim; j++) begin : g_col
            a_lane_t a_cell;
            b_lane_t b_cell;

            // A enters on the left edge, B on the top edge.
            if (j == 0) begin : g_a_edge
                assign a_cell = a_skewed[i];
            end else begin : g_a_mesh
                assign a_cell = a_fwd[i][j-1];
            end

            if (i == 0) begin : g_b_edge
                assign b_cell = b_skewed[j];
            end else begin : g_b_mesh
                assign b_cell = b_fwd[i-1][j];
            end

            mac_pe i_pe (
                .clk   (clk),
                .rst   (rst),
                .a_in  (a_cell),
                .b_in  (b_cell),
                .a_out (a_fwd[i][j]),
                .b_out (b_fwd[i][j]),
                .sum   (sums[i][j]),
                .done  (done[i][j])
            );
        end
    end

endmodule

//--- build.f
+incdir+sim
common/systolic_pkg.sv
skew/lane_skew.sv
array/mac_pe.sv
array/pe_grid.sv
rtl/result_drain.sv
rtl/matmul_top.sv
sim/tb_matmul.sv

//--- common/systolic_pkg.sv
package systolic_pkg;

    // array geometry and arithmetic widths.
    localparam int array_dim = 16;
    localparam int data_w    = 16;
    localparam int acc_w     = 40;
    localparam int row_idx_w = 4;

    typedef logic signed [data_w-1:0] data_t;
    typedef logic signed [acc_w-1:0]  acc_t;

    // one A lane, tags ride along with the operand.
    typedef struct packed {
        logic  valid;
        logic  first;
        logic  last;
        data_t data;
    } a_lane_t;

    // one B lane, operand only.
    typedef struct packed {
        data_t data;
    } b_lane_t;

    typedef a_lane_t [array_dim-1:0] a_vec_t;
    typedef b_lane_t [array_dim-1:0] b_vec_t;

    // elements keep the signed acc_t type when selected.
    typedef acc_t [array_dim-1:0] acc_row_t;

    // per-cell status and sums, indexed [row][col].
    typedef logic [array_dim-1:0][array_dim-1:0] done_grid_t;
    typedef acc_row_t [array_dim-1:0]            sum_grid_t;

    // output beat, one result row.
    typedef struct packed {
        logic                 valid;
        logic                 last;
        logic [row_idx_w-1:0] row;
        acc_row_t             data;
    } result_t;

endpackage

//--- rtl/matmul_top.sv
`timescale 1ns/100ps

module matmul_top (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       in_valid,
    input  logic                                       in_first,
    input  logic                                       in_last,
    input  systolic_pkg::data_t [systolic_pkg::array_dim-1:0] a_col,
    input  systolic_pkg::data_t [systolic_pkg::array_dim-1:0] b_row,
    output systolic_pkg::result_t                      res
);
    import systolic_pkg::*;

    a_vec_t     a_lanes;
    b_vec_t     b_lanes;
    a_vec_t     a_skewed;
    b_vec_t     b_skewed;
    done_grid_t done;
    sum_grid_t  sums;

    // every A lane carries its own copy of the beat tags.
    always_comb begin
        for (int k = 0; k < array_dim; k++) begin
            a_lanes[k].valid = in_valid;
            a_lanes[k].first = in_first;
            a_lanes[k].last  = in_last;
            a_lanes[k].data  = a_col[k];
            b_lanes[k].data  = b_row[k];
        end
    end

    lane_skew #(.lane_t(a_lane_t)) i_a_skew (
        .clk       (clk),
        .rst       (rst),
        .lanes_in  (a_lanes),
        .lanes_out (a_skewed)
    );

    lane_skew #(.lane_t(b_lane_t)) i_b_skew (
        .clk       (clk),
        .rst       (rst),
        .lanes_in  (b_lanes),
        .lanes_out (b_skewed)
    );

    pe_grid i_grid (
        .clk      (clk),
        .rst      (rst),
        .a_skewed (a_skewed),
        .b_skewed (b_skewed),
        .done     (done),
        .sums     (sums)
    );

    result_drain i_drain (
        .clk  (clk),
        .rst  (rst),
        .done (done),
        .sums (sums),
        .res  (res)
    );

endmodule

//--- rtl/result_drain.sv
`timescale 1ns/100ps

module result_drain (
    input  logic                     clk,
    input  logic                     rst,
    input  systolic_pkg::done_grid_t done,
    input  systolic_pkg::sum_grid_t  sums,
    output systolic_pkg::result_t    res
);
    import systolic_pkg::*;

    acc_row_t             row_buf [array_dim];
    logic                 row_hit;
    logic [row_idx_w-1:0] row_sel;
    acc_row_t             row_merged;

    // cells along a row finish one per cycle, left to right.
    always_ff @(posedge clk) begin
        for (int i = 0; i < array_dim; i++) begin
            for (int j = 0; j < array_dim; j++) begin
                if (done[i][j]) begin
                    row_buf[i][j] <= sums[i][j];
                end
            end
        end
    end

    // at most one row closes per cycle, jobs are 16 beats apart.
    always_comb begin
        row_hit = 1'b0;
        row_sel = '0;
        for (int i = 0; i < array_dim; i++) begin
            if (done[i][array_dim-1]) begin
                row_hit = 1'b1;
                row_sel = row_idx_w'(i);
            end
        end
    end

    // cells finishing this cycle bypass the buffer.
    always_comb begin
        for (int j = 0; j < array_dim; j++) begin
            if (done[row_sel][j]) begin
                row_merged[j] = sums[row_sel][j];
            end else begin
                row_merged[j] = row_buf[row_sel][j];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res.valid <= 1'b0;
            res.last  <= 1'b0;
        end else begin
            res.valid <= row_hit;
            res.last  <= row_hit && (row_sel == row_idx_w'(array_dim - 1));
        end
        res.row  <= row_sel;
        res.data <= row_merged;
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the matmul testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

log=sim_run.log
rm -rf obj_dir "$log"

{ verilator --binary --timing --timescale 1ns/100ps \
      --top-module tb_matmul -Mdir obj_dir -f build.f \
  && ./obj_dir/Vtb_matmul; } > "$log" 2>&1 \
  || echo "build or simulation ended with an error, see $log"

tail -n 3 "$log"

grep -q '^\*\*\* PASSED \*\*\*$' "$log" \
  && { echo "result: pass"; exit 0; } \
  || { echo "result: fail"; exit 1; }

//--- sim/tb_matmul_model.svh
`ifndef TB_MATMUL_MODEL_SVH
`define TB_MATMUL_MODEL_SVH

function automatic int rand_operand();
    logic signed [15:0] v;
    v = 16'($random(seed));
    return int'(v);
endfunction

// plain integer product, wide enough that nothing wraps.
function automatic void compute_product(input int j);
    longint acc;
    for (int r = 0; r < array_dim; r++) begin
        for (int c = 0; c < array_dim; c++) begin
            acc = 0;
            for (int k = 0; k < array_dim; k++) begin
                acc += longint'(job_a[j][r][k]) * longint'(job_b[j][k][c]);
            end
            job_c[j][r][c] = acc;
        end
    end
endfunction

// job 0 identity, 1 and 2 extremes, 4 back to back, 5 gapped, 6 cut by reset.
task automatic fill_job_table;
    int beats;
    total_cycles = 0;
    for (int j = 0; j < num_jobs; j++) begin
        job_b2b[j]   = (j == 4);
        job_abort[j] = (j == 6) ? array_dim : -1;
        for (int k = 0; k < array_dim; k++) begin
            job_gap[j][k] = (j == 5) ? (rand_operand() & 3) : 0;
        end
        if (!job_b2b[j]) begin
            job_gap[j][0] = job_idle;
        end
        for (int r = 0; r < array_dim; r++) begin
            for (int c = 0; c < array_dim; c++) begin
                case (j)
                    0: begin
                        job_a[j][r][c] = (r == c) ? 1 : 0;
                        job_b[j][r][c] = r * array_dim + c - 128;
                    end
                    1: begin
                        job_a[j][r][c] = -32768;
                        job_b[j][r][c] = -32768;
                    end
                    2: begin
                        job_a[j][r][c] = 32767;
                        job_b[j][r][c] = -32768;
                    end
                    default: begin
                        job_a[j][r][c] = rand_operand();
                        job_b[j][r][c] = rand_operand();
                    end
                endcase
            end
        end
        compute_product(j);
        beats = (job_abort[j] >= 0) ? job_abort[j] : array_dim;
        total_cycles += beats;
        for (int k = 0; k < beats; k++) begin
            total_cycles += job_gap[j][k];
        end
        if (job_abort[j] >= 0) begin
            total_cycles += reset_cycles + 1;
        end
    end
endtask

task automatic compare_row(input int j, input int r);
    logic signed [acc_w-1:0] got;
    rows_checked++;
    for (int c = 0; c < array_dim; c++) begin
        got = res.data[c];
        if (longint'(got) != job_c[j][r][c]) begin
            mon_errors++;
            $display("Mismatch at %0t: res.data row %0d column %0d expected %0d actual %0d",
                     $time, r, c, job_c[j][r][c], got);
        end
    end
    if (int'(res.row) != r) begin
        mon_errors++;
        $display("Mismatch at %0t: res.row expected %0d actual %0d", $time, r, res.row);
    end
    if (res.last !== (r == array_dim - 1)) begin
        mon_errors++;
        $display("Mismatch at %0t: res.last expected %0d actual %0d",
                 $time, (r == array_dim - 1), res.last);
    end
endtask

`endif

//--- sim/tb_matmul.sv
`timescale 1ns/100ps

module tb_matmul;
    import systolic_pkg::*;

    localparam int num_jobs     = 8;
    localparam int reset_cycles = 8;
    localparam int job_idle     = 3;
    localparam int drain_wait   = 2 * array_dim + 12;

    logic                  clk;
    logic                  rst;
    logic                  in_valid;
    logic                  in_first;
    logic                  in_last;
    data_t [array_dim-1:0] a_col;
    data_t [array_dim-1:0] b_row;
    result_t               res;

    // job table, indexed [job][row][col] for the matrices.
    int     job_a     [num_jobs][array_dim][array_dim];
    int     job_b     [num_jobs][array_dim][array_dim];
    longint job_c     [num_jobs][array_dim][array_dim];
    int     job_gap   [num_jobs][array_dim];
    bit     job_b2b   [num_jobs];
    int     job_abort [num_jobs];

    // expected rows in arrival order.
    int exp_job [$];
    int exp_row [$];

    int seed;
    int total_cycles;
    int timeout_limit;
    int cycle_count  = 0;
    int mon_errors   = 0;
    int run_errors   = 0;
    int rows_checked = 0;

    `include "tb_matmul_model.svh"

    matmul_top i_dut (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_first (in_first),
        .in_last  (in_last),
        .a_col    (a_col),
        .b_row    (b_row),
        .res      (res)
    );

    always #5 clk = ~clk;

    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            in_valid <= 1'b0;
            in_first <= 1'b0;
            in_last  <= 1'b0;
        end
    endtask

    // beat k carries column k of A and row k of B.
    task automatic drive_beat(input int j, input int k);
        @(posedge clk);
        in_valid <= 1'b1;
        in_first <= (k == 0);
        in_last  <= (k == array_dim - 1);
        for (int r = 0; r < array_dim; r++) begin
            a_col[r] <= data_t'(job_a[j][r][k]);
            b_row[r] <= data_t'(job_b[j][k][r]);
        end
    endtask

    task automatic apply_reset;
        @(posedge clk);
        rst      <= 1'b1;
        in_valid <= 1'b0;
        in_first <= 1'b0;
        in_last  <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic apply_job(input int j);
        int beats;
        beats = (job_abort[j] >= 0) ? job_abort[j] : array_dim;
        if (job_abort[j] < 0) begin
            for (int r = 0; r < array_dim; r++) begin
                exp_job.push_back(j);
                exp_row.push_back(r);
            end
        end
        for (int k = 0; k < beats; k++) begin
            drive_idle(job_gap[j][k]);
            drive_beat(j, k);
        end
        // reset while the job is still in flight, nothing of it may come out.
        if (job_abort[j] >= 0) begin
            apply_reset();
        end
    endtask

    task automatic wait_drain;
        int waited;
        waited = 0;
        drive_idle(1);
        while (exp_job.size() != 0 && waited < drain_wait) begin
            @(posedge clk);
            waited++;
        end
        if (exp_job.size() != 0) begin
            run_errors++;
            $display("Error at %0t: result rows missing (%0d)", $time, exp_job.size());
            exp_job.delete();
            exp_row.delete();
        end
    endtask

    task automatic finish_run(input bit timed_out);
        int total;
        total = mon_errors + run_errors;
        if (timed_out) begin
            total++;
        end
        $display("summary: %0d errors, %0d rows checked, %0d cycles",
                 total, rows_checked, cycle_count);
        if (total == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_first = 1'b0;
        in_last  = 1'b0;
        a_col    = '0;
        b_row    = '0;
        seed     = 86;
        fill_job_table();
        timeout_limit = reset_cycles + total_cycles + 2 * (2 * array_dim + 2) + 50;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        for (int j = 0; j < num_jobs; j++) begin
            if (job_abort[j] >= 0) begin
                wait_drain();
            end
            apply_job(j);
        end
        wait_drain();
        repeat (8) @(posedge clk);
        finish_run(1'b0);
    end

    // outputs sampled mid-cycle, away from the active edge.
    always @(negedge clk) begin
        if (rst) begin
            if (res.valid === 1'b1) begin
                mon_errors++;
                $display("Error at %0t: res.valid high during reset", $time);
            end
        end else if (res.valid === 1'b1) begin
            if (exp_job.size() == 0) begin
                mon_errors++;
                $display("Error at %0t: unexpected result row %0d", $time, res.row);
            end else begin
                compare_row(exp_job.pop_front(), exp_row.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Error at %0t: timeout after %0d cycles", $time, cycle_count);
            finish_run(1'b1);
        end
    end

endmodule

//--- skew/lane_skew.sv
`timescale 1ns/100ps

module lane_skew #(
    parameter type lane_t = systolic_pkg::a_lane_t
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  lane_t [systolic_pkg::array_dim-1:0]  lanes_in,
    output lane_t [systolic_pkg::array_dim-1:0]  lanes_out
);
    import systolic_pkg::*;

    // triangular bank, lane k holds k+1 stages.
    for (genvar k = 0; k < array_dim; k++) begin : g_lane
        lane_t [k:0] sr;

        always_ff @(posedge clk) begin
            if (rst) begin
                sr <= '0;
            end else begin
                sr[0] <= lanes_in[k];
                for (int s = 1; s <= k; s++) begin
                    sr[s] <= sr[s-1];
                end
            end
        end

        // oldest stage feeds the grid edge.
        assign lanes_out[k] = sr[k];
    end

endmodule
